/* ddr3_bridge.f */
+incdir+rtl
rtl/ddr3_bridge_pkg.sv
rtl/ddr3_cmd_if.sv
rtl/ddr3_port_arbiter.sv
rtl/ddr3_cmd_queue.sv
rtl/ddr3_avl_master.sv
rtl/ddr3_bridge.sv
tb/avl_mem_model.sv
tb/tb_ddr3_bridge.sv

/* rtl/ddr3_avl_master.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr3_avl_master (
  input  logic                      clk,
  input  logic                      rst,
  ddr3_cmd_if.sink                  cmd,

  input  logic                      avl_ready_i,
  input  logic                      avl_rdata_valid_i,
  input  ddr3_bridge_pkg::line_t    avl_rdata_i,
  output logic                      avl_read_o,
  output logic                      avl_write_o,
  output ddr3_bridge_pkg::avl_addr_t avl_addr_o,
  output ddr3_bridge_pkg::line_t    avl_wdata_o,

  output logic                      rsp_valid_o,
  output ddr3_bridge_pkg::line_t    rsp_data_o
);
  import ddr3_bridge_pkg::*;

  avl_state_e state;

  // one command at a time, so the queue is popped only when idle
  assign cmd.ready = (state == AVL_IDLE);

  always_ff @(posedge clk)
  begin
    if (state == AVL_IDLE && cmd.valid)
    begin
      avl_addr_o  <= cmd.addr;
      avl_wdata_o <= cmd.wdata;
    end
    if (state == AVL_RDATA && avl_rdata_valid_i)
      rsp_data_o <= avl_rdata_i;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= AVL_IDLE;
      avl_read_o  <= 1'b0;
      avl_write_o <= 1'b0;
      rsp_valid_o <= 1'b0;
    end
    else
    begin
      rsp_valid_o <= 1'b0;
      case (state)
        AVL_IDLE:
        begin
          if (cmd.valid)
          begin
            avl_read_o  <= !cmd.we;
            avl_write_o <= cmd.we;
            state       <= AVL_CMD;
          end
        end
        AVL_CMD:
        begin
          if (avl_ready_i)  // controller has taken the command
          begin
            avl_read_o  <= 1'b0;
            avl_write_o <= 1'b0;
            state       <= avl_read_o ? AVL_RDATA : AVL_IDLE;
          end
        end
        AVL_RDATA:
        begin
          if (avl_rdata_valid_i)
          begin
            rsp_valid_o <= 1'b1;
            state       <= AVL_IDLE;
          end
        end
        default: state <= AVL_IDLE;
      endcase
    end
  end

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(avl_read_o && avl_write_o));

endmodule

`default_nettype wire

/* rtl/ddr3_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr3_bridge (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       inst_stb_i,
  input  logic                       inst_we_i,
  input  ddr3_bridge_pkg::bus_addr_t inst_adr_i,
  input  ddr3_bridge_pkg::line_t     inst_dat_i,
  output logic                       inst_ack_o,
  output logic                       inst_stall_o,
  output ddr3_bridge_pkg::line_t     inst_dat_o,

  input  logic                       data_stb_i,
  input  logic                       data_we_i,
  input  ddr3_bridge_pkg::bus_addr_t data_adr_i,
  input  ddr3_bridge_pkg::line_t     data_dat_i,
  output logic                       data_ack_o,
  output logic                       data_stall_o,
  output ddr3_bridge_pkg::line_t     data_dat_o,

  input  logic                       avl_ready_i,
  input  logic                       avl_rdata_valid_i,
  input  ddr3_bridge_pkg::line_t     avl_rdata_i,
  output logic                       avl_read_o,
  output logic                       avl_write_o,
  output ddr3_bridge_pkg::avl_addr_t avl_addr_o,
  output ddr3_bridge_pkg::line_t     avl_wdata_o
);
  import ddr3_bridge_pkg::*;

  logic  rsp_valid;
  line_t rsp_data;

  ddr3_cmd_if cmd_in_if ();
  ddr3_cmd_if cmd_out_if ();

  ddr3_port_arbiter u_arbiter (
    .clk          (clk),
    .rst          (rst),
    .inst_stb_i   (inst_stb_i),
    .inst_we_i    (inst_we_i),
    .inst_adr_i   (inst_adr_i),
    .inst_dat_i   (inst_dat_i),
    .inst_ack_o   (inst_ack_o),
    .inst_stall_o (inst_stall_o),
    .inst_dat_o   (inst_dat_o),
    .data_stb_i   (data_stb_i),
    .data_we_i    (data_we_i),
    .data_adr_i   (data_adr_i),
    .data_dat_i   (data_dat_i),
    .data_ack_o   (data_ack_o),
    .data_stall_o (data_stall_o),
    .data_dat_o   (data_dat_o),
    .cmd          (cmd_in_if.source),
    .rsp_valid_i  (rsp_valid),
    .rsp_data_i   (rsp_data)
  );

  ddr3_cmd_queue u_cmd_queue (
    .clk (clk),
    .rst (rst),
    .wr  (cmd_in_if.sink),
    .rd  (cmd_out_if.source)
  );

  ddr3_avl_master u_avl_master (
    .clk               (clk),
    .rst               (rst),
    .cmd               (cmd_out_if.sink),
    .avl_ready_i       (avl_ready_i),
    .avl_rdata_valid_i (avl_rdata_valid_i),
    .avl_rdata_i       (avl_rdata_i),
    .avl_read_o        (avl_read_o),
    .avl_write_o       (avl_write_o),
    .avl_addr_o        (avl_addr_o),
    .avl_wdata_o       (avl_wdata_o),
    .rsp_valid_o       (rsp_valid),
    .rsp_data_o        (rsp_data)
  );

endmodule

`default_nettype wire

/* rtl/ddr3_bridge_cfg.svh */
`ifndef DDR3_BRIDGE_CFG_SVH
`define DDR3_BRIDGE_CFG_SVH

// width of the word address on both Wishbone ports
`define DDR3_BUS_ADDR_W 32

// the controller takes a 26 bit word address
`define DDR3_AVL_ADDR_W 26

`define DDR3_LINE_W 128

// the queue must hold a power of two entries, at least two
`define DDR3_CMD_DEPTH 4

`endif

/* rtl/ddr3_bridge_pkg.sv */
`default_nettype none

`include "ddr3_bridge_cfg.svh"

package ddr3_bridge_pkg;

  typedef logic [`DDR3_BUS_ADDR_W-1:0] bus_addr_t;
  typedef logic [`DDR3_AVL_ADDR_W-1:0] avl_addr_t;  // low bits of bus_addr_t
  typedef logic [`DDR3_LINE_W-1:0]     line_t;

  typedef enum logic {
    PORT_INST,
    PORT_DATA
  } port_sel_e;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_PUSH,
    ARB_WAIT_RSP
  } arb_state_e;

  typedef enum logic [1:0] {
    AVL_IDLE,
    AVL_CMD,
    AVL_RDATA
  } avl_state_e;

endpackage

`default_nettype wire

/* rtl/ddr3_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ddr3_cmd_if;
  import ddr3_bridge_pkg::*;

  logic      valid;
  logic      ready;
  logic      we;     // high for a write, low for a read
  avl_addr_t addr;
  line_t     wdata;

  modport source (
    output valid,
    output we,
    output addr,
    output wdata,
    input  ready
  );

  modport sink (
    input  valid,
    input  we,
    input  addr,
    input  wdata,
    output ready
  );

endinterface

`default_nettype wire

/* rtl/ddr3_cmd_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_bridge_cfg.svh"

module ddr3_cmd_queue #(
  parameter int DEPTH = `DDR3_CMD_DEPTH
) (
  input  logic       clk,
  input  logic       rst,
  ddr3_cmd_if.sink   wr,
  ddr3_cmd_if.source rd
);
  import ddr3_bridge_pkg::*;

  localparam int             PTR_W    = $clog2(DEPTH);
  localparam logic [PTR_W:0] CNT_FULL = (PTR_W+1)'(DEPTH);

  logic             we_mem    [DEPTH];
  avl_addr_t        addr_mem  [DEPTH];
  line_t            wdata_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;   // both pointers wrap by overflow
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign wr.ready = (count != CNT_FULL);
  assign rd.valid = (count != '0);
  assign push     = wr.valid && wr.ready;
  assign pop      = rd.valid && rd.ready;

  assign rd.we    = we_mem[rd_ptr];
  assign rd.addr  = addr_mem[rd_ptr];
  assign rd.wdata = wdata_mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      we_mem[wr_ptr]    <= wr.we;
      addr_mem[wr_ptr]  <= wr.addr;
      wdata_mem[wr_ptr] <= wr.wdata;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) count <= CNT_FULL);

endmodule

`default_nettype wire

/* rtl/ddr3_port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr3_port_arbiter (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       inst_stb_i,
  input  logic                       inst_we_i,
  input  ddr3_bridge_pkg::bus_addr_t inst_adr_i,
  input  ddr3_bridge_pkg::line_t     inst_dat_i,
  output logic                       inst_ack_o,
  output logic                       inst_stall_o,
  output ddr3_bridge_pkg::line_t     inst_dat_o,

  input  logic                       data_stb_i,
  input  logic                       data_we_i,
  input  ddr3_bridge_pkg::bus_addr_t data_adr_i,
  input  ddr3_bridge_pkg::line_t     data_dat_i,
  output logic                       data_ack_o,
  output logic                       data_stall_o,
  output ddr3_bridge_pkg::line_t     data_dat_o,

  ddr3_cmd_if.source                 cmd,

  input  logic                       rsp_valid_i,
  input  ddr3_bridge_pkg::line_t     rsp_data_i
);
  import ddr3_bridge_pkg::*;

  arb_state_e state;
  port_sel_e  owner;      // port whose transfer is in progress
  port_sel_e  prio;
  port_sel_e  next_prio;
  port_sel_e  grant_sel;
  logic       grant_valid;
  bus_addr_t  grant_adr;

  logic       cmd_we_q;
  avl_addr_t  cmd_addr_q;
  line_t      cmd_wdata_q;

  // the prioritized port wins, the other one only when it is alone
  always_comb
  begin
    if (prio == PORT_INST)
      grant_sel = inst_stb_i ? PORT_INST : PORT_DATA;
    else
      grant_sel = data_stb_i ? PORT_DATA : PORT_INST;
    grant_valid = (state == ARB_IDLE) && (inst_stb_i || data_stb_i);
    grant_adr   = (grant_sel == PORT_INST) ? inst_adr_i : data_adr_i;
  end

  assign next_prio    = (owner == PORT_INST) ? PORT_DATA : PORT_INST;
  assign inst_stall_o = !(grant_valid && grant_sel == PORT_INST);
  assign data_stall_o = !(grant_valid && grant_sel == PORT_DATA);

  assign cmd.valid = (state == ARB_PUSH);
  assign cmd.we    = cmd_we_q;
  assign cmd.addr  = cmd_addr_q;
  assign cmd.wdata = cmd_wdata_q;

  always_ff @(posedge clk)
  begin
    if (grant_valid)
    begin
      cmd_we_q    <= (grant_sel == PORT_INST) ? inst_we_i : data_we_i;
      cmd_addr_q  <= grant_adr[$bits(avl_addr_t)-1:0];  // drop the bits above the DDR3 range
      cmd_wdata_q <= (grant_sel == PORT_INST) ? inst_dat_i : data_dat_i;
    end
    if (state == ARB_WAIT_RSP && rsp_valid_i)
    begin
      if (owner == PORT_INST)
        inst_dat_o <= rsp_data_i;
      else
        data_dat_o <= rsp_data_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= ARB_IDLE;
      owner      <= PORT_INST;
      prio       <= PORT_INST;
      inst_ack_o <= 1'b0;
      data_ack_o <= 1'b0;
    end
    else
    begin
      inst_ack_o <= 1'b0;
      data_ack_o <= 1'b0;
      case (state)
        ARB_IDLE:
        begin
          if (grant_valid)
          begin
            owner <= grant_sel;
            state <= ARB_PUSH;
          end
        end
        ARB_PUSH:
        begin
          if (cmd.ready)
          begin
            if (cmd_we_q)
            begin
              inst_ack_o <= (owner == PORT_INST);  // writes finish once queued
              data_ack_o <= (owner == PORT_DATA);
              prio       <= next_prio;
              state      <= ARB_IDLE;
            end
            else
              state <= ARB_WAIT_RSP;
          end
        end
        ARB_WAIT_RSP:
        begin
          if (rsp_valid_i)
          begin
            inst_ack_o <= (owner == PORT_INST);
            data_ack_o <= (owner == PORT_DATA);
            prio       <= next_prio;
            state      <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  a_one_ack: assert property (@(posedge clk) disable iff (rst) !(inst_ack_o && data_ack_o));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_ddr3_bridge \
  -f ddr3_bridge.f \
  --Mdir obj_dir -o sim_ddr3_bridge

./obj_dir/sim_ddr3_bridge | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "testbench reported errors, see sim.log"
  exit 1
fi
echo "simulation log written to sim.log"

/* tb/avl_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module avl_mem_model #(
  parameter int READ_LAT = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       avl_read_i,
  input  logic                       avl_write_i,
  input  ddr3_bridge_pkg::avl_addr_t avl_addr_i,
  input  ddr3_bridge_pkg::line_t     avl_wdata_i,
  output logic                       avl_ready_o,
  output logic                       avl_rdata_valid_o,
  output ddr3_bridge_pkg::line_t     avl_rdata_o
);
  import ddr3_bridge_pkg::*;

  line_t mem [avl_addr_t];
  int    seed;
  int    rd_cnt;
  int    r;
  line_t rd_line;
  logic  ready_next;
  logic  valid_next;

  // unwritten lines read back as a pattern of their own address
  function automatic line_t fill_line(input avl_addr_t a);
    return {24'h0, a, ~a, a, ~a};
  endfunction

  initial
  begin
    seed              = 32'ha747_73c0;
    rd_cnt            = 0;
    rd_line           = '0;
    avl_ready_o       = 1'b0;
    avl_rdata_valid_o = 1'b0;
    avl_rdata_o       = '0;
    forever
    begin
      @(posedge clk);
      valid_next = 1'b0;
      if (rst)
        rd_cnt = 0;
      else
      begin
        if (rd_cnt != 0)
        begin
          rd_cnt     = rd_cnt - 1;
          valid_next = (rd_cnt == 0);  // data returns a fixed time after the read is taken
        end
        if ((avl_read_i || avl_write_i) && avl_ready_o)
        begin
          if (avl_write_i)
            mem[avl_addr_i] = avl_wdata_i;
          else
          begin
            rd_line = mem.exists(avl_addr_i) ? mem[avl_addr_i] : fill_line(avl_addr_i);
            rd_cnt  = READ_LAT;
          end
        end
      end
      r          = $random(seed);
      ready_next = (r[1:0] != 2'b00);  // wait state on about one cycle in four
      #1;
      avl_ready_o       = ready_next;
      avl_rdata_valid_o = valid_next;
      avl_rdata_o       = rd_line;
    end
  end

endmodule

`default_nettype wire

/* tb/tb_ddr3_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ddr3_bridge;
  import ddr3_bridge_pkg::*;

  localparam int XFER_COUNT        = 68;   // transfers issued by all tests together
  localparam int XFER_WORST_CYCLES = 400;
  localparam int TIMEOUT_CYCLES    = XFER_COUNT * XFER_WORST_CYCLES;
  localparam int READ_LAT          = 4;

  logic      clk;
  logic      rst;
  logic      inst_stb, inst_we, inst_ack, inst_stall;
  bus_addr_t inst_adr;
  line_t     inst_dat_w, inst_dat_r;
  logic      data_stb, data_we, data_ack, data_stall;
  bus_addr_t data_adr;
  line_t     data_dat_w, data_dat_r;
  logic      avl_ready, avl_rdata_valid, avl_read, avl_write;
  line_t     avl_rdata, avl_wdata;
  avl_addr_t avl_addr;

  int        seed;
  int        errors;
  int        checks;
  int        cycles;
  int        inst_reqs, data_reqs, inst_acks, data_acks;
  port_sel_e last_grant;
  line_t     sb [avl_addr_t];   // last line written to each DDR3 address
  avl_addr_t addr_log [$];      // addresses of completed Avalon commands

  ddr3_bridge u_dut (
    .clk (clk), .rst (rst),
    .inst_stb_i (inst_stb), .inst_we_i (inst_we), .inst_adr_i (inst_adr),
    .inst_dat_i (inst_dat_w), .inst_ack_o (inst_ack), .inst_stall_o (inst_stall),
    .inst_dat_o (inst_dat_r),
    .data_stb_i (data_stb), .data_we_i (data_we), .data_adr_i (data_adr),
    .data_dat_i (data_dat_w), .data_ack_o (data_ack), .data_stall_o (data_stall),
    .data_dat_o (data_dat_r),
    .avl_ready_i (avl_ready), .avl_rdata_valid_i (avl_rdata_valid), .avl_rdata_i (avl_rdata),
    .avl_read_o (avl_read), .avl_write_o (avl_write), .avl_addr_o (avl_addr),
    .avl_wdata_o (avl_wdata)
  );

  avl_mem_model #(.READ_LAT (READ_LAT)) u_mem (
    .clk (clk), .rst (rst),
    .avl_read_i (avl_read), .avl_write_i (avl_write), .avl_addr_i (avl_addr),
    .avl_wdata_i (avl_wdata), .avl_ready_o (avl_ready), .avl_rdata_valid_o (avl_rdata_valid),
    .avl_rdata_o (avl_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_line(input string name, input line_t got, input line_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input avl_addr_t got, input avl_addr_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  function automatic logic port_stall(input port_sel_e port);
    return (port == PORT_INST) ? inst_stall : data_stall;
  endfunction

  function automatic logic port_ack(input port_sel_e port);
    return (port == PORT_INST) ? inst_ack : data_ack;
  endfunction

  function automatic line_t random_line();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic drive_req(input port_sel_e port, input logic stb, input logic we,
                           input bus_addr_t adr, input line_t dat);
    if (port == PORT_INST)
    begin
      inst_stb   = stb;
      inst_we    = we;
      inst_adr   = adr;
      inst_dat_w = dat;
    end
    else
    begin
      data_stb   = stb;
      data_we    = we;
      data_adr   = adr;
      data_dat_w = dat;
    end
  endtask

  // stall is looked at mid cycle, the request is taken on the next rising edge
  task automatic wait_accept(input port_sel_e port);
    logic done;
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      done = !port_stall(port);
      @(posedge clk);
    end
    #1;
    drive_req(port, 1'b0, 1'b0, '0, '0);
    if (port == PORT_INST)
      inst_reqs++;
    else
      data_reqs++;
  endtask

  task automatic wait_ack(input port_sel_e port, output line_t dat);
    logic done;
    done = 1'b0;
    dat  = '0;
    while (!done)
    begin
      @(negedge clk);
      done = port_ack(port);
    end
    dat = (port == PORT_INST) ? inst_dat_r : data_dat_r;
    @(posedge clk);
    #1;
  endtask

  task automatic wb_write(input port_sel_e port, input bus_addr_t adr, input line_t dat);
    line_t unused_dat;
    drive_req(port, 1'b1, 1'b1, adr, dat);
    wait_accept(port);
    wait_ack(port, unused_dat);
    sb[avl_addr_t'(adr)] = dat;
  endtask

  task automatic wb_read(input port_sel_e port, input bus_addr_t adr, output line_t dat);
    drive_req(port, 1'b1, 1'b0, adr, '0);
    wait_accept(port);
    wait_ack(port, dat);
  endtask

  task automatic read_check(input port_sel_e port, input bus_addr_t adr);
    line_t got;
    wb_read(port, adr, got);
    check_line((port == PORT_INST) ? "inst_dat_o" : "data_dat_o", got, sb[avl_addr_t'(adr)]);
  endtask

  // bus checks that hold in every test, sampled mid cycle
  always @(negedge clk)
  begin
    if (rst)
    begin
      last_grant = PORT_DATA;
      inst_acks  = 0;
      data_acks  = 0;
    end
    else
    begin
      if (inst_ack)
        inst_acks++;
      if (data_ack)
        data_acks++;
      if (inst_ack && data_ack)
      begin
        errors++;
        $display("ERROR both ports were acknowledged in the same cycle");
      end
      if ((inst_stb && !inst_stall) || (data_stb && !data_stall))
      begin
        if (inst_stb && data_stb)
          check_bit("inst_stall_o", inst_stall, last_grant == PORT_INST);
        last_grant = inst_stall ? PORT_DATA : PORT_INST;
      end
      if ((avl_read || avl_write) && avl_ready)
        addr_log.push_back(avl_addr);
    end
  end

  task automatic test_idle_levels();
    repeat (3)
    begin
      @(negedge clk);
      check_bit("inst_stall_o", inst_stall, 1'b1);
      check_bit("data_stall_o", data_stall, 1'b1);
      check_bit("inst_ack_o", inst_ack, 1'b0);
      check_bit("data_ack_o", data_ack, 1'b0);
      check_bit("avl_read_o", avl_read, 1'b0);
      check_bit("avl_write_o", avl_write, 1'b0);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic test_inst_write_read();
    wb_write(PORT_INST, 32'h0000_1040, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210);
    read_check(PORT_INST, 32'h0000_1040);
    check_count("inst_ack_o count", inst_acks, inst_reqs);
  endtask

  task automatic test_data_burst();
    bus_addr_t adr [4];
    int        i;
    addr_log.delete();
    for (i = 0; i < 4; i++)
    begin
      adr[i] = 32'hfc00_1000 + bus_addr_t'(i * 16);  // upper bits lie outside the DDR3 range
      wb_write(PORT_DATA, adr[i], {adr[i], 32'hdada_0000, ~adr[i], 32'h1234_5678});
    end
    for (i = 0; i < 4; i++)
      read_check(PORT_DATA, adr[i]);
    check_count("avl command count", addr_log.size(), 8);
    if (addr_log.size() == 8)
    begin
      for (i = 0; i < 8; i++)
        check_addr("avl_addr_o", addr_log[i], avl_addr_t'(adr[i % 4]));
    end
  endtask

  task automatic test_cross_port();
    wb_write(PORT_DATA, 32'h0000_2000, 128'hd0d0_d0d0_0000_1111_2222_3333_4444_5555);
    read_check(PORT_INST, 32'h0000_2000);
    wb_write(PORT_INST, 32'h0000_2010, 128'h1e1e_1e1e_6666_7777_8888_9999_aaaa_bbbb);
    read_check(PORT_DATA, 32'h0000_2010);
  endtask

  task automatic port_sequence(input port_sel_e port, input bus_addr_t base);
    wb_write(port, base, {base, 96'h5a5a_5a5a_0000_0000_0000_0001});
    wb_write(port, base + 32'h10, {base, 96'ha5a5_a5a5_0000_0000_0000_0002});
    read_check(port, base);
    read_check(port, base + 32'h10);
  endtask

  // the next write follows each accept at once, so the port is waiting again when the
  // arbiter returns to idle
  task automatic post_writes(input port_sel_e port, input bus_addr_t base);
    bus_addr_t adr;
    line_t     dat;
    int        i;
    for (i = 0; i < 2; i++)
    begin
      adr = base + bus_addr_t'(i * 16);
      dat = {adr, 32'hc0c0_0000, ~adr, bus_addr_t'(i)};
      drive_req(port, 1'b1, 1'b1, adr, dat);
      wait_accept(port);
      sb[avl_addr_t'(adr)] = dat;
    end
  endtask

  task automatic test_both_ports();
    int i;
    fork
      post_writes(PORT_INST, 32'h0000_5000);
      post_writes(PORT_DATA, 32'h0000_6000);
    join
    while (inst_acks != inst_reqs || data_acks != data_reqs)
      @(posedge clk);
    #1;
    for (i = 0; i < 2; i++)
    begin
      read_check(PORT_INST, 32'h0000_5000 + bus_addr_t'(i * 16));
      read_check(PORT_DATA, 32'h0000_6000 + bus_addr_t'(i * 16));
    end
    fork
      port_sequence(PORT_INST, 32'h0000_3000);
      port_sequence(PORT_DATA, 32'h0000_4000);
    join
  endtask

  task automatic test_random_mix();
    bus_addr_t pool [8];
    int        i;
    int        r;
    logic [2:0] idx;
    port_sel_e port;
    for (i = 0; i < 8; i++)
    begin
      pool[i] = $random(seed);
      wb_write(PORT_DATA, pool[i], random_line());
    end
    for (i = 0; i < 30; i++)
    begin
      r    = $random(seed);
      port = r[0] ? PORT_DATA : PORT_INST;
      idx  = r[3:1];
      if (r[4])
        wb_write(port, pool[idx], random_line());
      else
        read_check(port, pool[idx]);
    end
  endtask

  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a request was never acknowledged", cycles);
    $display("%0d errors in %0d checks", errors, checks);
    $display("sim failed");
    $finish;
  end

  initial
  begin
    seed      = 32'ha747_73c0;
    errors    = 0;
    checks    = 0;
    inst_reqs = 0;
    data_reqs = 0;
    rst       = 1'b1;
    drive_req(PORT_INST, 1'b0, 1'b0, '0, '0);
    drive_req(PORT_DATA, 1'b0, 1'b0, '0, '0);
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    test_idle_levels();
    test_inst_write_read();
    test_data_burst();
    test_cross_port();
    test_both_ports();
    test_random_mix();
    repeat (20) @(posedge clk);
    #1;
    check_count("inst_ack_o count", inst_acks, inst_reqs);
    check_count("data_ack_o count", data_acks, data_reqs);
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire
